// ==== Bender.yml ====
package:
  name: cu_control

sources:
  - source/cu_pkg.sv
  - source/cu_config_regs.sv
  - source/cu_read_engine.sv
  - source/cu_write_engine.sv
  - source/cu_job_status.sv
  - source/cu_control.sv
  - target: test
    files:
      - verif/cu_clock_gen.sv
      - verif/cu_control_checker.sv
      - verif/cu_control_properties.sv
      - verif/cu_control_tb.sv

// ==== flist.f ====
source/cu_pkg.sv
source/cu_config_regs.sv
source/cu_read_engine.sv
source/cu_write_engine.sv
source/cu_job_status.sv
source/cu_control.sv
verif/cu_clock_gen.sv
verif/cu_control_checker.sv
verif/cu_control_properties.sv
verif/cu_control_tb.sv

// ==== source/cu_config_regs.sv ====
`timescale 1ns/1ps

module cu_config_regs (
	input  logic              clock,
	input  logic              rstn,
	input  logic              enabled_in,
	input  cu_pkg::job_desc_t wed_request,
	input  cu_pkg::cu_mode_t  cu_configure,
	output logic              enabled,
	output cu_pkg::cu_mode_t  mode,
	output cu_pkg::job_desc_t job,
	output logic              job_start
);
	import cu_pkg::*;

	//////////////////////////////////////////////////
	// Host enable
	//////////////////////////////////////////////////

	// Registered once, everything downstream runs off this copy
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////////////////////////
	// Mode word
	//////////////////////////////////////////////////

	// An idle word from the host keeps the last mode
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			mode <= MODE_IDLE;
		end else begin
			if (enabled && (cu_configure != MODE_IDLE)) begin
				mode <= cu_configure;
			end
		end
	end

	//////////////////////////////////////////////////
	// Job descriptor
	//////////////////////////////////////////////////

	// Start pulse lines up with the new descriptor
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job       <= '0;
			job_start <= 1'b0;
		end else begin
			if (enabled) begin
				job_start <= wed_request.valid;
				if (wed_request.valid) begin
					job <= wed_request;
				end
			end
		end
	end

endmodule

// ==== source/cu_control.sv ====
`timescale 1ns/1ps

module cu_control (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled_in,
	input  cu_pkg::job_desc_t            wed_request,
	input  cu_pkg::cu_mode_t             cu_configure,
	input  cu_pkg::response_line_t       read_response,
	input  cu_pkg::response_line_t       write_response,
	input  logic                         read_buffer_full,
	input  logic                         write_buffer_full,
	output cu_pkg::command_line_t        read_command,
	output cu_pkg::command_line_t        write_command,
	output logic                         cu_done,
	output logic [cu_pkg::SIZE_BITS-1:0] cu_return,
	output cu_pkg::cu_mode_t             cu_status
);
	import cu_pkg::*;

	logic                 enabled;
	cu_mode_t             mode;
	job_desc_t            job;
	logic                 job_start;
	response_line_t       read_line;
	logic                 pop;
	logic [SIZE_BITS-1:0] read_done_count;
	logic [SIZE_BITS-1:0] write_done_count;

	//////////////////////////////////////////////////
	// Configuration
	//////////////////////////////////////////////////

	cu_config_regs cu_config_regs_i (
		.clock        (clock),
		.rstn         (rstn),
		.enabled_in   (enabled_in),
		.wed_request  (wed_request),
		.cu_configure (cu_configure),
		.enabled      (enabled),
		.mode         (mode),
		.job          (job),
		.job_start    (job_start)
	);

	//////////////////////////////////////////////////
	// Engines
	//////////////////////////////////////////////////

	cu_read_engine cu_read_engine_i (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.mode             (mode),
		.job              (job),
		.job_start        (job_start),
		.read_buffer_full (read_buffer_full),
		.read_response    (read_response),
		.pop              (pop),
		.read_command     (read_command),
		.read_line        (read_line),
		.read_done_count  (read_done_count)
	);

	// Pop strobe goes back as the read credit
	cu_write_engine cu_write_engine_i (
		.clock             (clock),
		.rstn              (rstn),
		.enabled           (enabled),
		.job               (job),
		.job_start         (job_start),
		.read_line         (read_line),
		.write_buffer_full (write_buffer_full),
		.write_response    (write_response),
		.pop               (pop),
		.write_command     (write_command),
		.write_done_count  (write_done_count)
	);

	//////////////////////////////////////////////////
	// Status
	//////////////////////////////////////////////////

	cu_job_status cu_job_status_i (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (enabled),
		.mode             (mode),
		.job              (job),
		.job_start        (job_start),
		.read_done_count  (read_done_count),
		.write_done_count (write_done_count),
		.cu_done          (cu_done),
		.cu_return        (cu_return),
		.cu_status        (cu_status)
	);

endmodule

// ==== source/cu_job_status.sv ====
`timescale 1ns/1ps

module cu_job_status (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  cu_pkg::cu_mode_t             mode,
	input  cu_pkg::job_desc_t            job,
	input  logic                         job_start,
	input  logic [cu_pkg::SIZE_BITS-1:0] read_done_count,
	input  logic [cu_pkg::SIZE_BITS-1:0] write_done_count,
	output logic                         cu_done,
	output logic [cu_pkg::SIZE_BITS-1:0] cu_return,
	output cu_pkg::cu_mode_t             cu_status
);
	import cu_pkg::*;

	logic                 done_next;
	logic [SIZE_BITS-1:0] return_next;

	// Copy jobs finish on the writes, read-only jobs on the reads
	always_comb begin
		done_next   = 1'b0;
		return_next = '0;
		if (job.valid) begin
			case (mode)
				MODE_COPY: begin
					done_next   = (write_done_count == job.size_send);
					return_next = write_done_count;
				end
				MODE_READ: begin
					done_next   = (read_done_count == job.size_send);
					return_next = read_done_count;
				end
				default: begin
					done_next   = 1'b0;
					return_next = '0;
				end
			endcase
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_done   <= 1'b0;
			cu_return <= '0;
			cu_status <= MODE_IDLE;
		end else begin
			if (enabled) begin
				cu_status <= mode;
				// Counts of the old job are still visible on the start cycle
				if (job_start) begin
					cu_done   <= 1'b0;
					cu_return <= '0;
				end else begin
					cu_done   <= done_next;
					cu_return <= return_next;
				end
			end
		end
	end

endmodule

// ==== source/cu_pkg.sv ====
package cu_pkg;

	//////////////////////////////////////////////////
	// Widths and limits
	//////////////////////////////////////////////////

	// Host byte address
	localparam int ADDR_BITS       = 64;
	// Address step from one cache line to the next
	localparam int LINE_BYTES      = 128;
	localparam int LINE_DATA_BITS  = 64;
	// Array sizes and job counters count lines
	localparam int SIZE_BITS       = 32;
	// Tag carries the line index
	localparam int TAG_BITS        = 32;
	// Read credits, same as the line buffer depth
	localparam int MAX_OUTSTANDING = 8;
	localparam int CREDIT_BITS     = $clog2(MAX_OUTSTANDING + 1);
	localparam int BUF_PTR_BITS    = $clog2(MAX_OUTSTANDING);

	//////////////////////////////////////////////////
	// Modes and opcodes
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		MODE_IDLE = 2'd0,
		MODE_READ = 2'd1,
		MODE_COPY = 2'd2
	} cu_mode_t;

	typedef enum logic {
		CMD_READ  = 1'b0,
		CMD_WRITE = 1'b1
	} cmd_opcode_t;

	//////////////////////////////////////////////////
	// Bus lines
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                 valid;
		logic [ADDR_BITS-1:0] array_send;
		logic [ADDR_BITS-1:0] array_receive;
		logic [SIZE_BITS-1:0] size_send;
	} job_desc_t;

	typedef struct packed {
		logic                      valid;
		cmd_opcode_t               opcode;
		logic [ADDR_BITS-1:0]      address;
		logic [TAG_BITS-1:0]       tag;
		logic [LINE_DATA_BITS-1:0] data;
	} command_line_t;

	// Data is only meaningful on read responses
	typedef struct packed {
		logic                      valid;
		logic [TAG_BITS-1:0]       tag;
		logic [LINE_DATA_BITS-1:0] data;
	} response_line_t;

endpackage

// ==== source/cu_read_engine.sv ====
`timescale 1ns/1ps

module cu_read_engine (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  cu_pkg::cu_mode_t             mode,
	input  cu_pkg::job_desc_t            job,
	input  logic                         job_start,
	input  logic                         read_buffer_full,
	input  cu_pkg::response_line_t       read_response,
	input  logic                         pop,
	output cu_pkg::command_line_t        read_command,
	output cu_pkg::response_line_t       read_line,
	output logic [cu_pkg::SIZE_BITS-1:0] read_done_count
);
	import cu_pkg::*;

	logic [SIZE_BITS-1:0]   line_index;
	logic [SIZE_BITS-1:0]   cur_index;
	logic [CREDIT_BITS-1:0] credits;
	command_line_t          issue_cmd;
	command_line_t          new_cmd;
	logic                   advance;
	logic                   issue;
	logic                   refund;

	//////////////////////////////////////////////////
	// Issue decision
	//////////////////////////////////////////////////

	// A fresh job starts from line zero in its first cycle
	assign cur_index = job_start ? '0 : line_index;

	// Issue slot moves on only if the host was not full last cycle
	assign advance = issue_cmd.valid && !read_buffer_full;

	assign issue = (mode != MODE_IDLE) && job.valid && (cur_index < job.size_send) &&
		(credits != '0) && (!issue_cmd.valid || advance);

	// Copy mode gets credits back when the line leaves the buffer
	assign refund = (mode == MODE_COPY) ? pop : read_response.valid;

	always_comb begin
		new_cmd         = '0;
		new_cmd.valid   = 1'b1;
		new_cmd.opcode  = CMD_READ;
		new_cmd.address = job.array_send + ADDR_BITS'(cur_index) * ADDR_BITS'(LINE_BYTES);
		new_cmd.tag     = TAG_BITS'(cur_index);
	end

	//////////////////////////////////////////////////
	// Line index and credits
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_index <= '0;
			credits    <= CREDIT_BITS'(MAX_OUTSTANDING);
		end else begin
			if (enabled) begin
				line_index <= cur_index + SIZE_BITS'(issue);
				credits    <= credits - CREDIT_BITS'(issue) + CREDIT_BITS'(refund);
			end
		end
	end

	//////////////////////////////////////////////////
	// Issue and output registers
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_cmd    <= '0;
			read_command <= '0;
		end else begin
			if (enabled) begin
				if (issue) begin
					issue_cmd <= new_cmd;
				end else if (advance) begin
					issue_cmd.valid <= 1'b0;
				end
				// Held in the issue slot while the host is full
				if (advance) begin
					read_command <= issue_cmd;
				end else begin
					read_command.valid <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Responses
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_done_count <= '0;
		end else begin
			if (enabled) begin
				if (job_start) begin
					read_done_count <= '0;
				end else if (read_response.valid) begin
					read_done_count <= read_done_count + SIZE_BITS'(1);
				end
			end
		end
	end

	// Read-only jobs drop the data here
	always_comb begin
		read_line       = read_response;
		read_line.valid = read_response.valid && (mode == MODE_COPY);
	end

endmodule

// ==== source/cu_write_engine.sv ====
`timescale 1ns/1ps

module cu_write_engine (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         enabled,
	input  cu_pkg::job_desc_t            job,
	input  logic                         job_start,
	input  cu_pkg::response_line_t       read_line,
	input  logic                         write_buffer_full,
	input  cu_pkg::response_line_t       write_response,
	output logic                         pop,
	output cu_pkg::command_line_t        write_command,
	output logic [cu_pkg::SIZE_BITS-1:0] write_done_count
);
	import cu_pkg::*;

	logic [TAG_BITS-1:0]       buf_tag  [MAX_OUTSTANDING];
	logic [LINE_DATA_BITS-1:0] buf_data [MAX_OUTSTANDING];
	logic [BUF_PTR_BITS-1:0]   wr_ptr;
	logic [BUF_PTR_BITS-1:0]   rd_ptr;
	logic [CREDIT_BITS-1:0]    fill;
	logic                      push;
	command_line_t             next_write;

	function automatic logic [BUF_PTR_BITS-1:0] next_ptr(input logic [BUF_PTR_BITS-1:0] ptr);
		logic [BUF_PTR_BITS-1:0] result;
		if (ptr == BUF_PTR_BITS'(MAX_OUTSTANDING - 1)) begin
			result = '0;
		end else begin
			result = ptr + BUF_PTR_BITS'(1);
		end
		return result;
	endfunction

	//////////////////////////////////////////////////
	// Line buffer
	//////////////////////////////////////////////////

	assign push = enabled && read_line.valid;

	// One entry leaves per write issued
	assign pop = enabled && (fill != '0) && !write_buffer_full;

	always_ff @(posedge clock) begin
		if (push) begin
			buf_tag[wr_ptr]  <= read_line.tag;
			buf_data[wr_ptr] <= read_line.data;
		end
	end

	// Read credits keep the fill at or below the depth
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end else begin
			if (push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			fill <= fill + CREDIT_BITS'(push) - CREDIT_BITS'(pop);
		end
	end

	//////////////////////////////////////////////////
	// Write commands
	//////////////////////////////////////////////////

	// Destination line is picked by the tag, so order does not matter
	always_comb begin
		next_write         = '0;
		next_write.valid   = 1'b1;
		next_write.opcode  = CMD_WRITE;
		next_write.address = job.array_receive +
			ADDR_BITS'(buf_tag[rd_ptr]) * ADDR_BITS'(LINE_BYTES);
		next_write.tag     = buf_tag[rd_ptr];
		next_write.data    = buf_data[rd_ptr];
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_command <= '0;
		end else begin
			if (enabled) begin
				if (pop) begin
					write_command <= next_write;
				end else begin
					write_command.valid <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Responses
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			write_done_count <= '0;
		end else begin
			if (enabled) begin
				if (job_start) begin
					write_done_count <= '0;
				end else if (write_response.valid) begin
					write_done_count <= write_done_count + SIZE_BITS'(1);
				end
			end
		end
	end

endmodule

// ==== verif/cu_clock_gen.sv ====
`timescale 1ns/1ps

module cu_clock_gen (
	output logic clock,
	output logic rstn
);
	localparam time PERIOD      = 40ns;
	localparam int  RESET_CYCLES = 3;

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Release lands just after an edge, away from the sampling point
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#2 rstn = 1'b1;
	end

endmodule

// ==== verif/cu_control_checker.sv ====
`timescale 1ns/1ps

module cu_control_checker (
	input logic                         clock,
	input logic                         rstn,
	input cu_pkg::job_desc_t            wed_request,
	input cu_pkg::cu_mode_t             cu_configure,
	input cu_pkg::response_line_t       read_response,
	input cu_pkg::response_line_t       write_response,
	input logic                         read_buffer_full,
	input logic                         write_buffer_full,
	input cu_pkg::command_line_t        read_command,
	input cu_pkg::command_line_t        write_command,
	input logic                         cu_done,
	input logic [cu_pkg::SIZE_BITS-1:0] cu_return,
	input cu_pkg::cu_mode_t             cu_status
);
	import cu_pkg::*;

	localparam int MAX_LINES = 64;

	int        error_count = 0;
	int        test_errors = 0;
	int        tests_run = 0;
	int        tests_reported = 0;
	int        tests_failed = 0;
	int        jobs_seen = 0;
	int        reads;
	int        writes;
	int        responses;
	int        outstanding = 0;
	int        peak = 0;
	int        credit_errors = 0;
	int        load_age = 3;
	bit        started = 0;
	bit        job_active = 0;
	bit        prev_done = 0;
	bit        prev_rfull = 0;
	bit        prev_wfull = 0;
	bit        read_seen [MAX_LINES];
	bit        write_seen [MAX_LINES];
	job_desc_t job;
	cu_mode_t  job_mode;

	// Reference: the line at the source address of the same index
	function automatic logic [63:0] expected_write_data(input logic [63:0] array_send,
		input logic [31:0] tag);
		logic [63:0] addr;
		addr = array_send + 64'(tag) * 64'(LINE_BYTES);
		return addr ^ {addr[31:0], addr[63:32]} ^ 64'hc3a5_0f1e_7b29_d468;
	endfunction

	function automatic int test_number(input int job_num);
		case (job_num)
			1: return 2;
			2: return 3;
			3: return 4;
			default: return 6;
		endcase
	endfunction

	task automatic value_error(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("** Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
		error_count++;
		test_errors++;
	endtask

	task automatic rule_error(input string text);
		$display("Error at %0t ns: %s", $time, text);
		error_count++;
		test_errors++;
	endtask

	task automatic end_test(input string text);
		$display("test %0d: %s, %0d errors", tests_run + 1, text, test_errors);
		tests_run++;
		tests_reported++;
		if (test_errors != 0)
			tests_failed++;
		test_errors = 0;
	endtask

	//////////////////////////////////////////////////
	// Job start and finish
	//////////////////////////////////////////////////

	task automatic start_job();
		if (!started)
			end_test("reset and idle outputs");
		started    = 1;
		job        = wed_request;
		job_mode   = cu_configure;
		reads      = 0;
		writes     = 0;
		responses  = 0;
		load_age   = 0;
		job_active = 1;
		jobs_seen++;
		for (int i = 0; i < MAX_LINES; i++) begin
			read_seen[i]  = 0;
			write_seen[i] = 0;
		end
	endtask

	task automatic finish_job();
		int size;
		size = int'(job.size_send);
		if (reads != size)
			value_error("read command count", reads, size);
		if (writes != ((job_mode == MODE_COPY) ? size : 0))
			value_error("write command count", writes, (job_mode == MODE_COPY) ? size : 0);
		// Done only after the host returned every line
		if (responses != size)
			value_error("response count", responses, size);
		if (cu_return != job.size_send)
			value_error("cu_return", cu_return, job.size_send);
		if (cu_status != job_mode)
			value_error("cu_status", cu_status, job_mode);
		for (int i = 0; i < size; i++) begin
			if (!read_seen[i])
				rule_error($sformatf("no read command for line %0d", i));
			if (job_mode == MODE_COPY && !write_seen[i])
				rule_error($sformatf("no write command for line %0d", i));
		end
		tests_run = test_number(jobs_seen) - 1;
		end_test($sformatf("%s job of %0d lines", job_mode.name(), size));
		job_active = 0;
	endtask

	//////////////////////////////////////////////////
	// Port watch, half a cycle after each edge
	//////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!started && (read_command.valid || write_command.valid || cu_done ||
			cu_return != '0 || cu_status != MODE_IDLE))
			rule_error("outputs not idle during reset or before the first job");
		if (job_active && load_age < 3) begin
			load_age++;
			if (load_age == 2 && (cu_done || cu_return != '0))
				rule_error("cu_done or cu_return not cleared by the new job");
		end
		if (rstn && wed_request.valid)
			start_job();
		// Full seen at the last check is what the DUT sampled for this command
		if (read_command.valid && prev_rfull)
			rule_error("read command issued after read_buffer_full was high");
		if (write_command.valid && prev_wfull)
			rule_error("write command issued after write_buffer_full was high");
		prev_rfull = read_buffer_full;
		prev_wfull = write_buffer_full;
		if (read_command.valid) begin
			if (read_command.opcode != CMD_READ)
				value_error("read_command.opcode", read_command.opcode, CMD_READ);
			// Lines go out in index order
			if (read_command.tag != reads)
				value_error("read_command.tag", read_command.tag, reads);
			if (read_command.tag >= job.size_send || read_command.tag >= MAX_LINES)
				rule_error("read command tag outside the job");
			else if (read_seen[read_command.tag])
				rule_error("read command tag issued twice");
			else
				read_seen[read_command.tag] = 1;
			if (read_command.address != job.array_send + 64'(reads) * LINE_BYTES)
				value_error("read_command.address", read_command.address,
					job.array_send + 64'(reads) * LINE_BYTES);
			reads++;
			outstanding++;
		end
		if (write_command.valid) begin
			writes++;
			if (job_mode == MODE_COPY)
				outstanding--;
			else
				rule_error("write command in read-only mode");
			if (write_command.opcode != CMD_WRITE)
				value_error("write_command.opcode", write_command.opcode, CMD_WRITE);
			if (write_command.tag >= job.size_send || write_command.tag >= MAX_LINES)
				rule_error("write command tag outside the job");
			else if (write_seen[write_command.tag])
				rule_error("write command tag issued twice");
			else
				write_seen[write_command.tag] = 1;
			if (write_command.address !=
				job.array_receive + 64'(write_command.tag) * LINE_BYTES)
				value_error("write_command.address", write_command.address,
					job.array_receive + 64'(write_command.tag) * LINE_BYTES);
			if (write_command.data != expected_write_data(job.array_send, write_command.tag))
				value_error("write_command.data", write_command.data,
					expected_write_data(job.array_send, write_command.tag));
		end
		if (read_response.valid && job_mode == MODE_READ)
			outstanding--;
		if (job_active) begin
			if (job_mode == MODE_COPY && write_response.valid)
				responses++;
			if (job_mode == MODE_READ && read_response.valid)
				responses++;
		end
		if (outstanding > peak)
			peak = outstanding;
		if (outstanding > MAX_OUTSTANDING) begin
			credit_errors++;
			rule_error("more reads outstanding than the credit limit");
		end
		if (cu_done && !prev_done && job_active)
			finish_job();
		prev_done = cu_done;
	end

	task automatic print_summary();
		if (job_active)
			rule_error("last job never raised cu_done");
		test_errors = credit_errors;
		tests_run   = 4;
		end_test($sformatf("credit limit, peak of %0d outstanding reads", peak));
		$display("summary: %0d tests, %0d failing, %0d errors", tests_reported,
			tests_failed, error_count);
	endtask

endmodule

// ==== verif/cu_control_properties.sv ====
`timescale 1ns/1ps

module cu_control_properties (
	input logic                         clock,
	input logic                         rstn,
	input cu_pkg::cu_mode_t             mode,
	input cu_pkg::command_line_t        read_command,
	input cu_pkg::command_line_t        write_command,
	input cu_pkg::response_line_t       read_response,
	input logic                         read_buffer_full,
	input logic                         write_buffer_full,
	input logic                         cu_done,
	input logic [cu_pkg::SIZE_BITS-1:0] cu_return,
	input cu_pkg::cu_mode_t             cu_status
);
	import cu_pkg::*;

	int outstanding;
	int failures = 0;

	// Reads not yet paid back by a write (copy) or a response (read)
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			outstanding <= 0;
		end else begin
			outstanding <= outstanding + int'(read_command.valid) -
				((mode == MODE_COPY) ? int'(write_command.valid) : int'(read_response.valid));
		end
	end

	// Outputs have settled half a cycle after the edge
	reset_idle: assert property (@(negedge clock) !rstn |-> !read_command.valid &&
		!write_command.valid && !cu_done && cu_return == '0 && cu_status == MODE_IDLE)
		else begin
			$error("outputs not idle in reset");
			failures++;
		end

	read_halt: assert property (@(posedge clock) disable iff (!rstn)
		read_command.valid |-> !$past(read_buffer_full))
		else begin
			$error("read command after read_buffer_full");
			failures++;
		end

	write_halt: assert property (@(posedge clock) disable iff (!rstn)
		write_command.valid |-> !$past(write_buffer_full))
		else begin
			$error("write command after write_buffer_full");
			failures++;
		end

	credit_limit: assert property (@(posedge clock) disable iff (!rstn)
		outstanding <= MAX_OUTSTANDING)
		else begin
			$error("outstanding reads above the credit limit");
			failures++;
		end

endmodule

bind cu_control cu_control_properties cu_control_properties_i (
	.clock             (clock),
	.rstn              (rstn),
	.mode              (mode),
	.read_command      (read_command),
	.write_command     (write_command),
	.read_response     (read_response),
	.read_buffer_full  (read_buffer_full),
	.write_buffer_full (write_buffer_full),
	.cu_done           (cu_done),
	.cu_return         (cu_return),
	.cu_status         (cu_status)
);

// ==== verif/cu_control_tb.sv ====
`timescale 1ns/1ps

module cu_control_tb;
	import cu_pkg::*;

	localparam logic [31:0] SEED           = 32'h68e1;
	localparam int          COPY_LINES     = 20;
	localparam int          READ_LINES     = 13;
	localparam int          BP_LINES       = 30;
	localparam int          SECOND_LINES   = 5;
	localparam int          TIMEOUT_MARGIN = 200;
	localparam int          TIMEOUT_CYCLES =
		(COPY_LINES + READ_LINES + BP_LINES + SECOND_LINES) * 20 + TIMEOUT_MARGIN;

	logic                 clock;
	logic                 rstn;
	logic                 enabled_in;
	job_desc_t            wed_request;
	cu_mode_t             cu_configure;
	response_line_t       read_response;
	response_line_t       write_response;
	logic                 read_buffer_full;
	logic                 write_buffer_full;
	command_line_t        read_command;
	command_line_t        write_command;
	logic                 cu_done;
	logic [SIZE_BITS-1:0] cu_return;
	cu_mode_t             cu_status;

	logic [31:0]          lfsr;
	bit                   bp_enable;
	int                   cycles = 0;

	// Host pending lists, one entry per accepted command
	int                   rd_delay[$];
	logic [31:0]          rd_tag[$];
	logic [63:0]          rd_data[$];
	int                   wr_delay[$];
	logic [31:0]          wr_tag[$];

	cu_clock_gen cu_clock_gen_i (
		.clock (clock),
		.rstn  (rstn)
	);

	cu_control cu_control_i (
		.clock             (clock),
		.rstn              (rstn),
		.enabled_in        (enabled_in),
		.wed_request       (wed_request),
		.cu_configure      (cu_configure),
		.read_response     (read_response),
		.write_response    (write_response),
		.read_buffer_full  (read_buffer_full),
		.write_buffer_full (write_buffer_full),
		.read_command      (read_command),
		.write_command     (write_command),
		.cu_done           (cu_done),
		.cu_return         (cu_return),
		.cu_status         (cu_status)
	);

	cu_control_checker checker_i (
		.clock             (clock),
		.rstn              (rstn),
		.wed_request       (wed_request),
		.cu_configure      (cu_configure),
		.read_response     (read_response),
		.write_response    (write_response),
		.read_buffer_full  (read_buffer_full),
		.write_buffer_full (write_buffer_full),
		.read_command      (read_command),
		.write_command     (write_command),
		.cu_done           (cu_done),
		.cu_return         (cu_return),
		.cu_status         (cu_status)
	);

	// Galois LFSR, one step per bit taken
	function automatic int take_bits(input int n);
		int value;
		value = 0;
		for (int i = 0; i < n; i++) begin
			lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			value = (value << 1) | int'(lfsr[0]);
		end
		return value;
	endfunction

	// Host memory word, every address bit takes part
	function automatic logic [63:0] line_content(input logic [63:0] addr);
		return addr ^ {addr[31:0], addr[63:32]} ^ 64'hc3a5_0f1e_7b29_d468;
	endfunction

	//////////////////////////////////////////////////
	// Host model
	//////////////////////////////////////////////////

	always @(posedge clock) begin : host_model
		int pick;
		#2;
		if (read_command.valid) begin
			rd_delay.push_back(1 + take_bits(3) % 6);
			rd_tag.push_back(read_command.tag);
			rd_data.push_back(line_content(read_command.address));
		end
		if (write_command.valid) begin
			wr_delay.push_back(1 + take_bits(3) % 6);
			wr_tag.push_back(write_command.tag);
		end
		// First entry whose delay ran out goes back, so order gets mixed
		pick = -1;
		foreach (rd_delay[i]) begin
			rd_delay[i]--;
			if (rd_delay[i] <= 0 && pick < 0)
				pick = i;
		end
		read_response = '0;
		if (pick >= 0) begin
			read_response.valid = 1'b1;
			read_response.tag   = rd_tag[pick];
			read_response.data  = rd_data[pick];
			rd_delay.delete(pick);
			rd_tag.delete(pick);
			rd_data.delete(pick);
		end
		pick = -1;
		foreach (wr_delay[i]) begin
			wr_delay[i]--;
			if (wr_delay[i] <= 0 && pick < 0)
				pick = i;
		end
		write_response = '0;
		if (pick >= 0) begin
			write_response.valid = 1'b1;
			write_response.tag   = wr_tag[pick];
			wr_delay.delete(pick);
			wr_tag.delete(pick);
		end
		read_buffer_full  = bp_enable && (take_bits(2) == 3);
		write_buffer_full = bp_enable && (take_bits(2) == 3);
	end

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	task automatic run_job(input cu_mode_t mode, input logic [63:0] src,
		input logic [63:0] dst, input int lines);
		@(posedge clock);
		#2;
		wed_request.valid         = 1'b1;
		wed_request.array_send    = src;
		wed_request.array_receive = dst;
		wed_request.size_send     = SIZE_BITS'(lines);
		cu_configure              = mode;
		@(posedge clock);
		#2;
		wed_request  = '0;
		cu_configure = MODE_IDLE;
		// Old done has to drop before the new one counts
		@(negedge clock);
		while (cu_done)
			@(negedge clock);
		while (!cu_done)
			@(negedge clock);
		repeat (4) @(negedge clock);
	endtask

	initial begin
		lfsr              = SEED;
		bp_enable         = 1'b0;
		enabled_in        = 1'b0;
		wed_request       = '0;
		cu_configure      = MODE_IDLE;
		read_response     = '0;
		write_response    = '0;
		read_buffer_full  = 1'b0;
		write_buffer_full = 1'b0;
		@(posedge rstn);
		@(posedge clock);
		#2 enabled_in = 1'b1;
		repeat (4) @(posedge clock);
		run_job(MODE_COPY, 64'h0000_0001_0000_0000, 64'h0000_0002_0000_0000, COPY_LINES);
		run_job(MODE_READ, 64'h0000_0003_4000_0000, 64'h0000_0004_0000_0000, READ_LINES);
		bp_enable = 1'b1;
		run_job(MODE_COPY, 64'h0000_0005_0008_0000, 64'h0000_0006_0010_0000, BP_LINES);
		bp_enable = 1'b0;
		run_job(MODE_COPY, 64'h0000_0007_0000_1000, 64'h0000_0008_0000_2000, SECOND_LINES);
		checker_i.print_summary();
		if (checker_i.error_count == 0 &&
			cu_control_i.cu_control_properties_i.failures == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAILED");
			$finish;
		end
	end

endmodule
